//--- logic/commit_defines.svh
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

`define REG_W       32
`define INSTR_W     32
`define REG_ADDR_W  5
`define ALUOP_W     8
`define EXCP_NUM_W  16
`define ECODE_W     6
`define ESUBCODE_W  9
`define VPPN_W      19
`define PAGE_OFS_W  13
`define STALL_W     5

// alu operation codes that end a commit group
`define EXE_SYSCALL_OP  8'b0001_0101
`define EXE_BREAK_OP    8'b0001_0110
`define EXE_ERTN_OP     8'b0010_1010

`define ECODE_INT   6'h00
`define ECODE_PIL   6'h01
`define ECODE_PIS   6'h02
`define ECODE_PIF   6'h03
`define ECODE_PME   6'h04
`define ECODE_PPI   6'h07
`define ECODE_ADEF  6'h08
`define ECODE_ADEM  6'h08
`define ECODE_ALE   6'h09
`define ECODE_SYS   6'h0b
`define ECODE_BRK   6'h0c
`define ECODE_INE   6'h0d
`define ECODE_IPE   6'h0e
`define ECODE_TLBR  6'h3f

`define ESUBCODE_ADEF  9'h000
`define ESUBCODE_ADEM  9'h001

`define EXCP_ENTRY  32'h1c00_8000

`endif

//--- logic/commit_pkg.sv
`include "commit_defines.svh"

package commit_pkg;

    // faulting virtual address split at the 8 KB page boundary
    typedef struct packed {
        logic [`VPPN_W-1:0]     vppn;
        logic [`PAGE_OFS_W-1:0] offset;
    } bad_va_t;

    // result word, or the faulting address on a memory exception
    typedef union packed {
        logic [`REG_W-1:0] word;
        bad_va_t           va;
    } wb_data_u;

    // decoded cause handed to the exception csrs
    typedef struct packed {
        logic [`ECODE_W-1:0]    ecode;
        logic [`ESUBCODE_W-1:0] esubcode;
        logic                   va_error;
        logic [`REG_W-1:0]      badv;
        logic                   tlb_refill;
        logic                   tlb_excp;
        logic [`VPPN_W-1:0]     vppn;
    } excp_cause_t;

endpackage

//--- logic/wb_slot_if.sv
`timescale 1ns/100ps
`include "commit_defines.svh"

interface wb_slot_if
    import commit_pkg::*;
(
    input logic clk
);

    logic                    valid;
    logic [`ALUOP_W-1:0]     aluop;
    logic [`REG_W-1:0]       pc;
    logic [`INSTR_W-1:0]     instr;
    wb_data_u                wdata;
    logic [`REG_ADDR_W-1:0]  rd;
    logic                    we;
    logic [`EXCP_NUM_W-1:0]  excp_num;

    modport producer (
        output valid, aluop, pc, instr, wdata, rd, we, excp_num
    );

    // commit side also samples the clock for its checks
    modport consumer (
        input clk, valid, aluop, pc, instr, wdata, rd, we, excp_num
    );

endinterface

//--- logic/wb_stage.sv
`timescale 1ns/100ps
`include "commit_defines.svh"

module wb_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,

    input  logic                    mem0_valid_i,
    input  logic [`ALUOP_W-1:0]     mem0_aluop_i,
    input  logic [`REG_W-1:0]       mem0_pc_i,
    input  logic [`INSTR_W-1:0]     mem0_instr_i,
    input  logic [`REG_W-1:0]       mem0_wdata_i,
    input  logic [`REG_ADDR_W-1:0]  mem0_rd_i,
    input  logic                    mem0_we_i,
    input  logic [`EXCP_NUM_W-1:0]  mem0_excp_num_i,

    input  logic                    mem1_valid_i,
    input  logic [`ALUOP_W-1:0]     mem1_aluop_i,
    input  logic [`REG_W-1:0]       mem1_pc_i,
    input  logic [`INSTR_W-1:0]     mem1_instr_i,
    input  logic [`REG_W-1:0]       mem1_wdata_i,
    input  logic [`REG_ADDR_W-1:0]  mem1_rd_i,
    input  logic                    mem1_we_i,
    input  logic [`EXCP_NUM_W-1:0]  mem1_excp_num_i,

    wb_slot_if.producer             slot0,
    wb_slot_if.producer             slot1
);

    // a flush kills whatever mem hands over this cycle
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            slot0.valid <= 1'b0;
            slot1.valid <= 1'b0;
        end else begin
            slot0.valid <= mem0_valid_i;
            slot1.valid <= mem1_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        slot0.aluop      <= mem0_aluop_i;
        slot0.pc         <= mem0_pc_i;
        slot0.instr      <= mem0_instr_i;
        slot0.wdata.word <= mem0_wdata_i;
        slot0.rd         <= mem0_rd_i;
        slot0.we         <= mem0_we_i;
        slot0.excp_num   <= mem0_excp_num_i;
        slot1.aluop      <= mem1_aluop_i;
        slot1.pc         <= mem1_pc_i;
        slot1.instr      <= mem1_instr_i;
        slot1.wdata.word <= mem1_wdata_i;
        slot1.rd         <= mem1_rd_i;
        slot1.we         <= mem1_we_i;
        slot1.excp_num   <= mem1_excp_num_i;
    end

    // issue fills slot0 first, so slot1 alone means upstream lost an instruction
    a_slot_order: assert property (@(posedge clk) disable iff (rst)
        slot1.valid |-> slot0.valid)
        else $error("wb_stage: slot1 valid without slot0");

endmodule

//--- logic/commit_ctrl.sv
`timescale 1ns/100ps
`include "commit_defines.svh"

module commit_ctrl
    import commit_pkg::*;
(
    wb_slot_if.consumer             slot0,
    wb_slot_if.consumer             slot1,

    input  logic [1:0]              ex_stallreq_i,
    input  logic [1:0]              mem_stallreq_i,
    input  logic                    dispatch_stallreq_i,
    input  logic [`REG_W-1:0]       csr_era_i,

    output logic                    reg_we0_o,
    output logic [`REG_ADDR_W-1:0]  reg_waddr0_o,
    output logic [`REG_W-1:0]       reg_wdata0_o,
    output logic                    reg_we1_o,
    output logic [`REG_ADDR_W-1:0]  reg_waddr1_o,
    output logic [`REG_W-1:0]       reg_wdata1_o,
    output logic                    commit0_o,
    output logic                    commit1_o,

    output logic                    excp_o,
    output logic                    ertn_o,
    output logic [`REG_W-1:0]       era_o,
    output excp_cause_t             cause_o,

    output logic                    flush_o,
    output logic [`REG_W-1:0]       redirect_pc_o,
    output logic [`STALL_W-1:0]     stall_o
);

    logic                    excp0;
    logic                    excp1;
    logic                    s0_blocks_s1;
    logic                    ertn0;
    logic                    ertn1;
    logic [`EXCP_NUM_W-1:0]  excp_num;
    logic [`REG_W-1:0]       excp_pc;
    wb_data_u                excp_wdata;
    wb_data_u                fault_va;
    logic [3:0]              cause_idx;
    logic                    fetch_side;

    // slot0 excepting or ending the group squashes slot1
    assign excp0 = slot0.valid && (slot0.excp_num != '0);
    assign s0_blocks_s1 = excp0 || (slot0.valid && (slot0.aluop == `EXE_ERTN_OP ||
                          slot0.aluop == `EXE_SYSCALL_OP || slot0.aluop == `EXE_BREAK_OP));
    assign excp1 = slot1.valid && (slot1.excp_num != '0) && !s0_blocks_s1;

    assign commit0_o = slot0.valid && !excp0;
    assign commit1_o = slot1.valid && (slot1.excp_num == '0) && !s0_blocks_s1;

    assign reg_we0_o    = commit0_o && slot0.we;
    assign reg_waddr0_o = slot0.rd;
    assign reg_wdata0_o = slot0.wdata.word;
    assign reg_we1_o    = commit1_o && slot1.we;
    assign reg_waddr1_o = slot1.rd;
    assign reg_wdata1_o = slot1.wdata.word;

    assign ertn0  = commit0_o && (slot0.aluop == `EXE_ERTN_OP);
    assign ertn1  = commit1_o && (slot1.aluop == `EXE_ERTN_OP);
    assign excp_o = excp0 || excp1;
    assign ertn_o = ertn0 || ertn1;

    assign flush_o       = excp_o || ertn_o;
    assign redirect_pc_o = excp_o ? `EXCP_ENTRY : csr_era_i;

    // oldest exception wins
    always_comb begin
        if (excp0) begin
            excp_num   = slot0.excp_num;
            excp_pc    = slot0.pc;
            excp_wdata = slot0.wdata;
        end else if (excp1) begin
            excp_num   = slot1.excp_num;
            excp_pc    = slot1.pc;
            excp_wdata = slot1.wdata;
        end else begin
            excp_num   = '0;
            excp_pc    = '0;
            excp_wdata = '0;
        end
    end

    assign era_o = excp_pc;

    // lowest set bit has priority
    always_comb begin
        cause_idx = 4'd0;
        for (int i = `EXCP_NUM_W - 1; i >= 0; i--) begin
            if (excp_num[i]) begin
                cause_idx = 4'(i);
            end
        end
    end

    // fetch causes fault on the pc, data causes on the access address
    assign fetch_side     = (cause_idx >= 4'd1) && (cause_idx <= 4'd4);
    assign fault_va.word  = fetch_side ? excp_pc : excp_wdata.word;

    always_comb begin
        cause_o = '0;
        if (excp_o) begin
            case (cause_idx)
                4'd0: cause_o.ecode = `ECODE_INT;
                4'd1: begin
                    cause_o.ecode    = `ECODE_ADEF;
                    cause_o.esubcode = `ESUBCODE_ADEF;
                end
                4'd2, 4'd11: begin
                    cause_o.ecode      = `ECODE_TLBR;
                    cause_o.tlb_refill = 1'b1;
                end
                4'd3: cause_o.ecode = `ECODE_PIF;
                4'd4, 4'd13: cause_o.ecode = `ECODE_PPI;
                4'd5: cause_o.ecode = `ECODE_SYS;
                4'd6: cause_o.ecode = `ECODE_BRK;
                4'd7: cause_o.ecode = `ECODE_INE;
                4'd8: cause_o.ecode = `ECODE_IPE;
                4'd9: cause_o.ecode = `ECODE_ALE;
                4'd10: begin
                    cause_o.ecode    = `ECODE_ADEM;
                    cause_o.esubcode = `ESUBCODE_ADEM;
                end
                4'd12: cause_o.ecode = `ECODE_PME;
                4'd14: cause_o.ecode = `ECODE_PIS;
                default: cause_o.ecode = `ECODE_PIL;
            endcase
            cause_o.va_error = fetch_side || (cause_idx >= 4'd9);
            cause_o.tlb_excp = cause_idx inside {[4'd2:4'd4], [4'd11:4'd15]};
            if (cause_o.va_error) begin
                cause_o.badv = fault_va.word;
            end
            if (cause_o.tlb_excp) begin
                cause_o.vppn = fault_va.va.vppn;
            end
        end
    end

    // stall bits run {ex_mem, dispatch_ex, id_dispatch, if_id, unused}
    always_comb begin
        if ((|ex_stallreq_i) || (|mem_stallreq_i)) begin
            stall_o = 5'b11110;
        end else if (dispatch_stallreq_i) begin
            stall_o = 5'b11100;
        end else begin
            stall_o = 5'b00000;
        end
    end

    a_excp_ertn_excl: assert property (@(posedge slot0.clk) !(excp_o && ertn_o))
        else $error("commit_ctrl: exception and ertn in the same cycle");

    // a slot0 flush must take slot1 down with it
    a_slot0_squash: assert property (@(posedge slot0.clk) (excp0 || ertn0) |-> !commit1_o)
        else $error("commit_ctrl: slot1 retired behind a slot0 flush");

endmodule

//--- logic/excp_csr.sv
`timescale 1ns/100ps
`include "commit_defines.svh"

module excp_csr
    import commit_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    excp_i,
    input  logic                    ertn_i,
    input  logic [`REG_W-1:0]       era_i,
    input  excp_cause_t             cause_i,

    output logic [`REG_W-1:0]       era_o,
    output logic [`ECODE_W-1:0]     ecode_o,
    output logic [`ESUBCODE_W-1:0]  esubcode_o,
    output logic [`REG_W-1:0]       badv_o,
    output logic [`VPPN_W-1:0]      tlbehi_vppn_o
);

    // era and estat cause always move, badv and tlbehi only for their causes
    always_ff @(posedge clk) begin
        if (rst) begin
            era_o         <= '0;
            ecode_o       <= '0;
            esubcode_o    <= '0;
            badv_o        <= '0;
            tlbehi_vppn_o <= '0;
        end else if (excp_i) begin
            era_o      <= era_i;
            ecode_o    <= cause_i.ecode;
            esubcode_o <= cause_i.esubcode;
            if (cause_i.va_error) begin
                badv_o <= cause_i.badv;
            end
            if (cause_i.tlb_excp) begin
                tlbehi_vppn_o <= cause_i.vppn;
            end
        end
    end

    // address faults are never interrupts, so the stored code is real
    a_va_ecode: assert property (@(posedge clk) disable iff (rst)
        excp_i && (cause_i.va_error || cause_i.tlb_excp) |=> ecode_o != `ECODE_INT)
        else $error("excp_csr: address exception latched ecode 0");

    a_refill_ecode: assert property (@(posedge clk) disable iff (rst)
        excp_i && cause_i.tlb_refill |=> ecode_o == `ECODE_TLBR)
        else $error("excp_csr: tlb refill latched a different ecode");

    // ertn returns through an era that an earlier exception stored
    a_ertn_era: assert property (@(posedge clk) disable iff (rst)
        ertn_i |-> era_o != '0)
        else $error("excp_csr: ertn with no stored return address");

endmodule

//--- logic/commit_top.sv
`timescale 1ns/100ps
`include "commit_defines.svh"

module commit_top
    import commit_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    mem0_valid_i,
    input  logic [`ALUOP_W-1:0]     mem0_aluop_i,
    input  logic [`REG_W-1:0]       mem0_pc_i,
    input  logic [`INSTR_W-1:0]     mem0_instr_i,
    input  logic [`REG_W-1:0]       mem0_wdata_i,
    input  logic [`REG_ADDR_W-1:0]  mem0_rd_i,
    input  logic                    mem0_we_i,
    input  logic [`EXCP_NUM_W-1:0]  mem0_excp_num_i,

    input  logic                    mem1_valid_i,
    input  logic [`ALUOP_W-1:0]     mem1_aluop_i,
    input  logic [`REG_W-1:0]       mem1_pc_i,
    input  logic [`INSTR_W-1:0]     mem1_instr_i,
    input  logic [`REG_W-1:0]       mem1_wdata_i,
    input  logic [`REG_ADDR_W-1:0]  mem1_rd_i,
    input  logic                    mem1_we_i,
    input  logic [`EXCP_NUM_W-1:0]  mem1_excp_num_i,

    input  logic [1:0]              ex_stallreq_i,
    input  logic [1:0]              mem_stallreq_i,
    input  logic                    dispatch_stallreq_i,

    output logic                    reg_we0_o,
    output logic [`REG_ADDR_W-1:0]  reg_waddr0_o,
    output logic [`REG_W-1:0]       reg_wdata0_o,
    output logic                    reg_we1_o,
    output logic [`REG_ADDR_W-1:0]  reg_waddr1_o,
    output logic [`REG_W-1:0]       reg_wdata1_o,
    output logic                    commit0_o,
    output logic                    commit1_o,
    output logic                    flush_o,
    output logic [`REG_W-1:0]       redirect_pc_o,
    output logic [`STALL_W-1:0]     stall_o,

    output logic [`REG_W-1:0]       era_o,
    output logic [`ECODE_W-1:0]     ecode_o,
    output logic [`ESUBCODE_W-1:0]  esubcode_o,
    output logic [`REG_W-1:0]       badv_o,
    output logic [`VPPN_W-1:0]      tlbehi_vppn_o
);

    logic               excp;
    logic               ertn;
    logic [`REG_W-1:0]  excp_era;
    excp_cause_t        cause;

    wb_slot_if u_slot0_if (.clk(clk));
    wb_slot_if u_slot1_if (.clk(clk));

    wb_stage u_wb_stage (
        .flush_i (flush_o),
        .slot0   (u_slot0_if),
        .slot1   (u_slot1_if),
        .*
    );

    // stored era comes back as the ertn target
    commit_ctrl u_commit_ctrl (
        .slot0     (u_slot0_if),
        .slot1     (u_slot1_if),
        .csr_era_i (era_o),
        .excp_o    (excp),
        .ertn_o    (ertn),
        .era_o     (excp_era),
        .cause_o   (cause),
        .*
    );

    excp_csr u_excp_csr (
        .excp_i  (excp),
        .ertn_i  (ertn),
        .era_i   (excp_era),
        .cause_i (cause),
        .*
    );

endmodule

//--- test/tb_commit_top.sv
`timescale 1ns/100ps
`include "commit_defines.svh"

module tb_commit_top;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int TEST_CYCLES   = 70;
    localparam int MARGIN_CYCLES = 40;

    logic clk;
    logic rst;
    logic mem0_valid_i, mem1_valid_i, mem0_we_i, mem1_we_i;
    logic [7:0] mem0_aluop_i, mem1_aluop_i;
    logic [31:0] mem0_pc_i, mem1_pc_i, mem0_instr_i, mem1_instr_i;
    logic [31:0] mem0_wdata_i, mem1_wdata_i;
    logic [4:0] mem0_rd_i, mem1_rd_i;
    logic [15:0] mem0_excp_num_i, mem1_excp_num_i;
    logic [1:0] ex_stallreq_i, mem_stallreq_i;
    logic dispatch_stallreq_i;
    logic reg_we0_o, reg_we1_o, commit0_o, commit1_o, flush_o;
    logic [4:0] reg_waddr0_o, reg_waddr1_o, stall_o;
    logic [31:0] reg_wdata0_o, reg_wdata1_o, redirect_pc_o, era_o, badv_o;
    logic [5:0] ecode_o;
    logic [8:0] esubcode_o;
    logic [18:0] tlbehi_vppn_o;

    logic [31:0] lfsr_state;
    logic [31:0] stored_era;

    commit_top u_commit_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic logic [31:0] random_pc();
        return (take_bits(30) << 2) | 32'h1c00_0000;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic idle_inputs();
        mem0_valid_i <= 1'b0;
        mem0_aluop_i <= '0;
        mem0_pc_i <= '0;
        mem0_instr_i <= '0;
        mem0_wdata_i <= '0;
        mem0_rd_i <= '0;
        mem0_we_i <= 1'b0;
        mem0_excp_num_i <= '0;
        mem1_valid_i <= 1'b0;
        mem1_aluop_i <= '0;
        mem1_pc_i <= '0;
        mem1_instr_i <= '0;
        mem1_wdata_i <= '0;
        mem1_rd_i <= '0;
        mem1_we_i <= 1'b0;
        mem1_excp_num_i <= '0;
    endtask

    task automatic drive_slot(input int idx, input logic [7:0] aluop, input logic [31:0] pc,
                              input logic [31:0] wdata, input logic [4:0] rd,
                              input logic [15:0] excp);
        if (idx == 0) begin
            mem0_valid_i <= 1'b1;
            mem0_aluop_i <= aluop;
            mem0_pc_i <= pc;
            mem0_wdata_i <= wdata;
            mem0_rd_i <= rd;
            mem0_we_i <= 1'b1;
            mem0_excp_num_i <= excp;
        end else begin
            mem1_valid_i <= 1'b1;
            mem1_aluop_i <= aluop;
            mem1_pc_i <= pc;
            mem1_wdata_i <= wdata;
            mem1_rd_i <= rd;
            mem1_we_i <= 1'b1;
            mem1_excp_num_i <= excp;
        end
    endtask

    task automatic check_retire(input logic exp0, input logic exp1);
        compare_value("commit0_o", commit0_o, exp0);
        compare_value("reg_we0_o", reg_we0_o, exp0);
        compare_value("commit1_o", commit1_o, exp1);
        compare_value("reg_we1_o", reg_we1_o, exp1);
    endtask

    task automatic test_dual_retire();
        logic [31:0] pc0, pc1, d0, d1;
        logic [4:0] rd0, rd1;
        pc0 = random_pc();
        pc1 = pc0 + 32'd4;
        d0 = take_bits(32);
        d1 = take_bits(32);
        rd0 = 5'(take_bits(5));
        rd1 = 5'(take_bits(5));
        @(posedge clk);
        drive_slot(0, 8'h00, pc0, d0, rd0, 16'h0000);
        drive_slot(1, 8'h00, pc1, d1, rd1, 16'h0000);
        @(posedge clk);
        idle_inputs();
        @(negedge clk);
        check_retire(1'b1, 1'b1);
        compare_value("reg_waddr0_o", reg_waddr0_o, rd0);
        compare_value("reg_wdata0_o", reg_wdata0_o, d0);
        compare_value("reg_waddr1_o", reg_waddr1_o, rd1);
        compare_value("reg_wdata1_o", reg_wdata1_o, d1);
        compare_value("flush_o", flush_o, 1'b0);
    endtask

    task automatic test_slot0_excp();
        logic [31:0] pc0, addr;
        pc0 = random_pc();
        addr = take_bits(32);
        @(posedge clk);
        // ale plus a pme bit that must lose
        drive_slot(0, 8'h00, pc0, addr, 5'(take_bits(5)), 16'h1200);
        drive_slot(1, 8'h00, pc0 + 32'd4, take_bits(32), 5'(take_bits(5)), 16'h0000);
        @(posedge clk);
        idle_inputs();
        @(negedge clk);
        check_retire(1'b0, 1'b0);
        compare_value("flush_o", flush_o, 1'b1);
        compare_value("redirect_pc_o", redirect_pc_o, `EXCP_ENTRY);
        @(negedge clk);
        compare_value("era_o", era_o, pc0);
        compare_value("ecode_o", ecode_o, 6'h09);
        compare_value("esubcode_o", esubcode_o, 9'h000);
        compare_value("badv_o", badv_o, addr);
    endtask

    task automatic test_slot1_excp();
        logic [31:0] pc0, pc1;
        pc0 = random_pc();
        pc1 = pc0 + 32'd4;
        @(posedge clk);
        drive_slot(0, 8'h00, pc0, take_bits(32), 5'(take_bits(5)), 16'h0000);
        drive_slot(1, 8'h00, pc1, take_bits(32), 5'(take_bits(5)), 16'h0004);
        @(posedge clk);
        idle_inputs();
        @(negedge clk);
        check_retire(1'b1, 1'b0);
        compare_value("flush_o", flush_o, 1'b1);
        compare_value("redirect_pc_o", redirect_pc_o, `EXCP_ENTRY);
        @(negedge clk);
        compare_value("era_o", era_o, pc1);
        compare_value("ecode_o", ecode_o, 6'h3f);
        compare_value("badv_o", badv_o, pc1);
        compare_value("tlbehi_vppn_o", tlbehi_vppn_o, pc1[31:13]);
        stored_era = pc1;
    endtask

    // slot0 ends the group, slot1 must not retire
    task automatic test_group_end(input logic [7:0] aluop, input logic is_ertn);
        logic [31:0] pc0;
        pc0 = random_pc();
        @(posedge clk);
        drive_slot(0, aluop, pc0, take_bits(32), 5'(take_bits(5)), 16'h0000);
        drive_slot(1, 8'h00, pc0 + 32'd4, take_bits(32), 5'(take_bits(5)), 16'h0000);
        @(posedge clk);
        idle_inputs();
        @(negedge clk);
        check_retire(1'b1, 1'b0);
        compare_value("flush_o", flush_o, is_ertn);
        if (is_ertn)
            compare_value("redirect_pc_o", redirect_pc_o, stored_era);
        @(negedge clk);
        compare_value("era_o", era_o, stored_era);
    endtask

    task automatic test_stall();
        logic [4:0] exp;
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            ex_stallreq_i <= i[1:0];
            mem_stallreq_i <= i[3:2];
            dispatch_stallreq_i <= i[4];
            if (i[3:0] != 4'd0)
                exp = 5'b11110;
            else if (i[4])
                exp = 5'b11100;
            else
                exp = 5'b00000;
            @(negedge clk);
            compare_value("stall_o", stall_o, exp);
        end
        @(posedge clk);
        ex_stallreq_i <= '0;
        mem_stallreq_i <= '0;
        dispatch_stallreq_i <= 1'b0;
    endtask

    task automatic test_flush_shadow();
        logic [31:0] pc0;
        pc0 = random_pc();
        @(posedge clk);
        // ine in slot0 raises flush for one cycle
        drive_slot(0, 8'h00, pc0, take_bits(32), 5'(take_bits(5)), 16'h0080);
        @(posedge clk);
        idle_inputs();
        drive_slot(0, 8'h00, pc0 + 32'd8, take_bits(32), 5'(take_bits(5)), 16'h0000);
        drive_slot(1, 8'h00, pc0 + 32'd12, take_bits(32), 5'(take_bits(5)), 16'h0000);
        @(negedge clk);
        compare_value("flush_o", flush_o, 1'b1);
        @(posedge clk);
        idle_inputs();
        @(negedge clk);
        check_retire(1'b0, 1'b0);
        compare_value("flush_o", flush_o, 1'b0);
        compare_value("ecode_o", ecode_o, 6'h0d);
    endtask

    initial begin
        stored_era = '0;
        lfsr_state = 32'h9a51_c24d;
        rst <= 1'b1;
        ex_stallreq_i <= '0;
        mem_stallreq_i <= '0;
        dispatch_stallreq_i <= 1'b0;
        idle_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_retire(1'b0, 1'b0);
        compare_value("flush_o", flush_o, 1'b0);
        compare_value("era_o", era_o, 32'h0);
        test_dual_retire();
        test_slot0_excp();
        test_slot1_excp();
        test_group_end(`EXE_ERTN_OP, 1'b1);
        test_group_end(`EXE_SYSCALL_OP, 1'b0);
        test_group_end(`EXE_BREAK_OP, 1'b0);
        test_stall();
        test_flush_shadow();
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- build.f
+incdir+logic
logic/commit_pkg.sv
logic/wb_slot_if.sv
logic/wb_stage.sv
logic/commit_ctrl.sv
logic/excp_csr.sv
logic/commit_top.sv
test/tb_commit_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_commit_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal --timescale 1ns/100ps

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard logic/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "FAIL"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then echo "FAIL"; exit 1; \
	else echo "PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
